//--- hw/ipod_pkg.sv
package ipod_pkg;

  // ==============================
  // Flash side
  // ==============================

  // Word address into the sample flash
  typedef logic [22:0] flash_addr_t;
  // One flash word holds two samples
  typedef logic [31:0] flash_word_t;

  // ==============================
  // Audio side
  // ==============================

  // Single 16-bit sample, lower half of the word comes first
  typedef logic [15:0] half_sample_t;
  // Signed output byte, taken from the sample's upper byte
  typedef logic signed [7:0] audio_t;
  // Sample period in CLK_50M cycles
  typedef logic [15:0] period_t;

  // Roughly 44 kHz at 50 MHz
  localparam period_t DEFAULT_PERIOD = 16'd1136;
  // Change per speed event
  localparam period_t PERIOD_STEP = 16'd100;
  // Clamp limits
  localparam period_t MIN_PERIOD = 16'd236;
  localparam period_t MAX_PERIOD = 16'd4036;

endpackage

//--- hw/flash_sample_reader.sv
`timescale 1ns/100ps

module flash_sample_reader #(
  parameter ipod_pkg::flash_addr_t LAST_ADDR = 23'h7FFFF
) (
  input  logic                   CLK_50M,
  input  logic                   reset,
  input  logic                   restart,
  input  logic                   wb_ack,
  input  ipod_pkg::flash_word_t  wb_dat,
  input  logic                   free_ge2,
  output logic                   wb_cyc,
  output logic                   wb_stb,
  output ipod_pkg::flash_addr_t  wb_adr,
  output logic                   push,
  output ipod_pkg::half_sample_t push_data,
  output logic                   flush
);

  // FSM encodings
  localparam logic [1:0] ST_IDLE  = 2'd0;
  localparam logic [1:0] ST_REQ   = 2'd1;
  localparam logic [1:0] ST_UPPER = 2'd2;

  logic [1:0]             state;
  logic                   restart_q;
  logic                   restart_rise;
  logic                   discard;
  logic                   start_ok;
  ipod_pkg::half_sample_t upper_q;
  ipod_pkg::flash_addr_t  next_adr;

  // One flush per restart press
  assign restart_rise = restart && !restart_q;

  // New request only with room for both halves and no push or flush in flight
  assign start_ok = free_ge2 && !push && !flush && !restart_rise;

  // Address wraps after the last word
  assign next_adr = (wb_adr == LAST_ADDR) ? '0 : wb_adr + 1'b1;

  // Classic single read, strobe follows cycle
  assign wb_stb = wb_cyc;

  // ==============================
  // Read FSM
  // ==============================
  always_ff @(posedge CLK_50M)
  begin
    if (reset)
    begin
      state     <= ST_IDLE;
      wb_cyc    <= 1'b0;
      wb_adr    <= '0;
      push      <= 1'b0;
      flush     <= 1'b0;
      discard   <= 1'b0;
      restart_q <= 1'b0;
    end
    else
    begin
      restart_q <= restart;
      flush     <= restart_rise;
      // Push is a one-cycle strobe
      push      <= 1'b0;
      case (state)
        ST_IDLE:
        begin
          if (start_ok)
          begin
            wb_cyc <= 1'b1;
            state  <= ST_REQ;
          end
        end
        ST_REQ:
        begin
          if (wb_ack)
          begin
            wb_cyc <= 1'b0;
            if (discard || restart_rise)
            begin
              // Stale word after restart, dropped
              wb_adr  <= '0;
              discard <= 1'b0;
              state   <= ST_IDLE;
            end
            else
            begin
              // Lower half first, upper half parked
              push      <= 1'b1;
              push_data <= wb_dat[15:0];
              upper_q   <= wb_dat[31:16];
              wb_adr    <= next_adr;
              state     <= ST_UPPER;
            end
          end
          else if (restart_rise)
          begin
            // Bus cycle must finish, so remember to drop it
            discard <= 1'b1;
          end
        end
        ST_UPPER:
        begin
          state <= ST_IDLE;
          if (!restart_rise)
          begin
            push      <= 1'b1;
            push_data <= upper_q;
          end
        end
        default:
        begin
          state <= ST_IDLE;
        end
      endcase
      // Address may move freely outside an open cycle
      if (restart_rise && state != ST_REQ)
      begin
        wb_adr <= '0;
      end
    end
  end

endmodule

//--- hw/sample_fifo.sv
`timescale 1ns/100ps

module sample_fifo #(
  parameter int FIFO_DEPTH = 8
) (
  input  logic                   CLK_50M,
  input  logic                   reset,
  input  logic                   push,
  input  ipod_pkg::half_sample_t push_data,
  input  logic                   pop,
  input  logic                   flush,
  output ipod_pkg::half_sample_t head,
  output logic                   empty,
  output logic                   free_ge2
);

  localparam int AW = $clog2(FIFO_DEPTH);
  // Highest count that still leaves two free entries
  localparam logic [AW:0] LIMIT_2FREE = (AW + 1)'(FIFO_DEPTH - 2);

  ipod_pkg::half_sample_t mem [FIFO_DEPTH];
  logic [AW-1:0]          wr_ptr;
  logic [AW-1:0]          rd_ptr;
  logic [AW:0]            count;

  // Head shown without a read cycle
  assign head     = mem[rd_ptr];
  assign empty    = (count == '0);
  assign free_ge2 = (count <= LIMIT_2FREE);

  // Storage
  always_ff @(posedge CLK_50M)
  begin
    if (push && !flush)
    begin
      mem[wr_ptr] <= push_data;
    end
  end

  // ==============================
  // Pointers and occupancy
  // ==============================
  always_ff @(posedge CLK_50M)
  begin
    if (reset || flush)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      // Power-of-two depth, pointers wrap on their own
      if (push)
      begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop)
      begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

//--- hw/speed_period_ctrl.sv
`timescale 1ns/100ps

module speed_period_ctrl #(
  parameter int unsigned REPEAT_CYCLES = 5_000_000
) (
  input  logic              CLK_50M,
  input  logic              reset,
  input  logic              speed_up,
  input  logic              speed_down,
  input  logic              speed_reset,
  output ipod_pkg::period_t period
);

  localparam int CW = $clog2(REPEAT_CYCLES + 1);
  // Counter value on the last cycle of a repeat interval
  localparam logic [CW-1:0] RPT_LAST = CW'(REPEAT_CYCLES - 1);

  // Bit 0 is up, bit 1 is down
  logic [1:0] btn;
  logic [1:0] btn_q;
  logic [1:0] step;

  assign btn = {speed_down, speed_up};

  // Edge registers
  always_ff @(posedge CLK_50M)
  begin
    if (reset)
    begin
      btn_q <= 2'b00;
    end
    else
    begin
      btn_q <= btn;
    end
  end

  // ==============================
  // Repeat timing per direction
  // ==============================
  for (genvar i = 0; i < 2; i++)
  begin : g_rpt
    logic [CW-1:0] rpt_cnt;

    // Restart the interval on press, count while held
    always_ff @(posedge CLK_50M)
    begin
      if (reset || !btn[i] || !btn_q[i] || rpt_cnt == RPT_LAST)
      begin
        rpt_cnt <= '0;
      end
      else
      begin
        rpt_cnt <= rpt_cnt + 1'b1;
      end
    end

    // Step on the press itself, then once per interval
    assign step[i] = btn[i] && (!btn_q[i] || rpt_cnt == RPT_LAST);
  end

  // ==============================
  // Period register
  // ==============================
  always_ff @(posedge CLK_50M)
  begin
    if (reset || speed_reset)
    begin
      period <= ipod_pkg::DEFAULT_PERIOD;
    end
    else if (step[0])
    begin
      // Faster playback, shorter period
      if (period <= ipod_pkg::MIN_PERIOD + ipod_pkg::PERIOD_STEP)
        period <= ipod_pkg::MIN_PERIOD;
      else
        period <= period - ipod_pkg::PERIOD_STEP;
    end
    else if (step[1])
    begin
      if (period >= ipod_pkg::MAX_PERIOD - ipod_pkg::PERIOD_STEP)
        period <= ipod_pkg::MAX_PERIOD;
      else
        period <= period + ipod_pkg::PERIOD_STEP;
    end
  end

endmodule

//--- hw/sample_rate_player.sv
`timescale 1ns/100ps

module sample_rate_player (
  input  logic                   CLK_50M,
  input  logic                   reset,
  input  logic                   play,
  input  ipod_pkg::period_t      period,
  input  ipod_pkg::half_sample_t head,
  input  logic                   empty,
  output logic                   pop,
  output ipod_pkg::audio_t       audio,
  output logic                   audio_valid
);

  ipod_pkg::period_t timer;
  logic              tick;

  // Timer at its last count, or still cleared from reset
  assign tick = play && (timer <= 16'd1);
  // Empty FIFO on a tick means the sample is skipped
  assign pop  = tick && !empty;

  // ==============================
  // Sample timer
  // ==============================
  always_ff @(posedge CLK_50M)
  begin
    if (reset)
    begin
      timer       <= '0;
      audio_valid <= 1'b0;
    end
    else
    begin
      audio_valid <= pop;
      // Reload picks up speed changes at the next sample
      if (tick)
        timer <= period;
      else if (play)
        timer <= timer - 1'b1;
    end
  end

  // Output byte, upper half of the sample
  always_ff @(posedge CLK_50M)
  begin
    if (pop)
    begin
      audio <= ipod_pkg::audio_t'(head[15:8]);
    end
  end

endmodule

//--- hw/ipod_player_top.sv
`timescale 1ns/100ps

module ipod_player_top #(
  parameter ipod_pkg::flash_addr_t LAST_ADDR     = 23'h7FFFF,
  parameter int                    FIFO_DEPTH    = 8,
  parameter int unsigned           REPEAT_CYCLES = 5_000_000
) (
  input  logic                  CLK_50M,
  input  logic                  reset,
  input  logic                  play,
  input  logic                  restart,
  input  logic                  speed_up,
  input  logic                  speed_down,
  input  logic                  speed_reset,
  input  logic                  wb_ack,
  input  ipod_pkg::flash_word_t wb_dat,
  output logic                  wb_cyc,
  output logic                  wb_stb,
  output ipod_pkg::flash_addr_t wb_adr,
  output ipod_pkg::audio_t      audio,
  output logic                  audio_valid,
  output ipod_pkg::period_t     sample_period
);

  // Producer to buffer
  logic                   push;
  ipod_pkg::half_sample_t push_data;
  logic                   flush;
  logic                   free_ge2;
  // Buffer to consumer
  logic                   pop;
  ipod_pkg::half_sample_t head;
  logic                   empty;

  // ==============================
  // Flash producer
  // ==============================
  flash_sample_reader #(
    .LAST_ADDR (LAST_ADDR)
  ) i_reader (
    .CLK_50M   (CLK_50M),
    .reset     (reset),
    .restart   (restart),
    .wb_ack    (wb_ack),
    .wb_dat    (wb_dat),
    .free_ge2  (free_ge2),
    .wb_cyc    (wb_cyc),
    .wb_stb    (wb_stb),
    .wb_adr    (wb_adr),
    .push      (push),
    .push_data (push_data),
    .flush     (flush)
  );

  // Sample buffer
  sample_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) i_fifo (
    .CLK_50M   (CLK_50M),
    .reset     (reset),
    .push      (push),
    .push_data (push_data),
    .pop       (pop),
    .flush     (flush),
    .head      (head),
    .empty     (empty),
    .free_ge2  (free_ge2)
  );

  // ==============================
  // Speed and playback
  // ==============================
  speed_period_ctrl #(
    .REPEAT_CYCLES (REPEAT_CYCLES)
  ) i_speed (
    .CLK_50M     (CLK_50M),
    .reset       (reset),
    .speed_up    (speed_up),
    .speed_down  (speed_down),
    .speed_reset (speed_reset),
    .period      (sample_period)
  );

  sample_rate_player i_player (
    .CLK_50M     (CLK_50M),
    .reset       (reset),
    .play        (play),
    .period      (sample_period),
    .head        (head),
    .empty       (empty),
    .pop         (pop),
    .audio       (audio),
    .audio_valid (audio_valid)
  );

endmodule

//--- sim/ipod_player_assertions.sv
`timescale 1ns/100ps

module ipod_player_assertions (
  input logic                  CLK_50M,
  input logic                  reset,
  input logic                  wb_stb,
  input logic                  wb_ack,
  input ipod_pkg::flash_addr_t wb_adr,
  input logic                  push,
  input logic                  free_ge2,
  input logic                  pop,
  input logic                  flush
);

  // Count of assertion failures
  int failures = 0;
  // Occupancy rebuilt from the push and pop strobes alone
  int level;

  // Flush empties the buffer on the next edge
  always_ff @(posedge CLK_50M)
  begin
    if (reset || flush)
      level <= 0;
    else
      level <= level + int'(push) - int'(pop);
  end

  // ==============================
  // Wishbone request hold
  // ==============================
  a_stb_hold: assert property (@(posedge CLK_50M) disable iff (reset)
    wb_stb && !wb_ack |=> wb_stb && $stable(wb_adr))
  else
  begin
    failures++;
    $error("wb_stb or wb_adr changed before wb_ack");
  end

  // Only the upper half may land without two free entries
  a_push_room: assert property (@(posedge CLK_50M) disable iff (reset)
    push && !free_ge2 |-> $past(push))
  else
  begin
    failures++;
    $error("FIFO push without room for both halves");
  end

  // Player pops only samples the reader has pushed
  a_pop_empty: assert property (@(posedge CLK_50M) disable iff (reset)
    pop |-> level > 0)
  else
  begin
    failures++;
    $error("FIFO pop while empty");
  end

endmodule

bind ipod_player_top ipod_player_assertions i_assert (
  .CLK_50M  (CLK_50M),
  .reset    (reset),
  .wb_stb   (wb_stb),
  .wb_ack   (wb_ack),
  .wb_adr   (wb_adr),
  .push     (push),
  .free_ge2 (free_ge2),
  .pop      (pop),
  .flush    (flush)
);

//--- sim/tb_ipod_player.sv
`timescale 1ns/100ps

module tb_ipod_player;

  localparam ipod_pkg::flash_addr_t LAST_ADDR = 23'd7;
  localparam int FIFO_DEPTH    = 8;
  localparam int REPEAT_CYCLES = 50;
  // Enough bytes to cover a wrap of the flash
  localparam int MIN_AUDIO     = 20;

  logic                  CLK_50M;
  logic                  reset;
  logic                  play;
  logic                  restart;
  logic                  speed_up;
  logic                  speed_down;
  logic                  speed_reset;
  logic                  wb_ack;
  ipod_pkg::flash_word_t wb_dat;
  logic                  wb_cyc;
  logic                  wb_stb;
  ipod_pkg::flash_addr_t wb_adr;
  ipod_pkg::audio_t      audio;
  logic                  audio_valid;
  ipod_pkg::period_t     sample_period;

  // Flash image and trace steps
  ipod_pkg::flash_word_t mem [0:LAST_ADDR];
  logic [4:0]            step_ctl[$];
  int                    step_cycles[$];
  ipod_pkg::period_t     step_period[$];
  logic                  trace_loaded = 1'b0;
  longint                watchdog_ns;

  // Flash slave state
  integer seed;
  logic   busy;
  int     ack_delay;

  // Expected playback position
  int   exp_addr;
  bit   exp_half;
  int   audio_count;
  // Pacing monitor state
  int                gap;
  logic              clean;
  logic              play_prev;
  logic              period_changed;
  ipod_pkg::period_t period_prev;

  int audio_errors;
  int period_errors;
  int timing_errors;

  ipod_player_top #(
    .LAST_ADDR     (LAST_ADDR),
    .FIFO_DEPTH    (FIFO_DEPTH),
    .REPEAT_CYCLES (REPEAT_CYCLES)
  ) i_dut (
    .CLK_50M       (CLK_50M),
    .reset         (reset),
    .play          (play),
    .restart       (restart),
    .speed_up      (speed_up),
    .speed_down    (speed_down),
    .speed_reset   (speed_reset),
    .wb_ack        (wb_ack),
    .wb_dat        (wb_dat),
    .wb_cyc        (wb_cyc),
    .wb_stb        (wb_stb),
    .wb_adr        (wb_adr),
    .audio         (audio),
    .audio_valid   (audio_valid),
    .sample_period (sample_period)
  );

  // ==============================
  // Checks and reference model
  // ==============================
  task automatic check_audio(input ipod_pkg::audio_t got, input ipod_pkg::audio_t exp);
    if (got !== exp)
    begin
      audio_errors++;
      $display("ERROR %0t: audio byte %0d, expected %0d", $time, got, exp);
    end
  endtask

  task automatic check_period(input ipod_pkg::period_t got, input ipod_pkg::period_t exp);
    if (got !== exp)
    begin
      period_errors++;
      $display("ERROR %0t: sample_period %0d, expected %0d", $time, got, exp);
    end
  endtask

  // Upper byte of the selected half, lower half first
  function automatic ipod_pkg::audio_t expected_audio(input int addr, input bit half);
    ipod_pkg::flash_word_t w;
    w = mem[addr];
    return half ? w[31:24] : w[15:8];
  endfunction

  initial
  begin
    CLK_50M = 1'b0;
    forever #10 CLK_50M = ~CLK_50M;
  end

  // ==============================
  // Trace loading
  // ==============================
  initial
  begin : load_trace
    int                    fd;
    int                    n;
    int                    a;
    int                    p;
    int                    r;
    int                    u;
    int                    d;
    int                    s;
    int                    c;
    int                    e;
    ipod_pkg::flash_word_t w;
    string                 line;
    longint                total_cycles;
    total_cycles = 0;
    fd = $fopen("sim/ipod_trace.txt", "r");
    if (fd == 0)
    begin
      $display("Could not open trace file sim/ipod_trace.txt");
      $display("Simulation FAILED");
      $finish;
    end
    else
    begin
      while (!$feof(fd))
      begin
        line = "";
        n = $fgets(line, fd);
        if (n > 0 && line.len() > 0 && line.getc(0) == "M")
        begin
          n = $sscanf(line, "M %h %h", a, w);
          mem[a] = w;
        end
        else if (n > 0 && line.len() > 0 && line.getc(0) == "S")
        begin
          n = $sscanf(line, "S %d %d %d %d %d %d %d", p, r, u, d, s, c, e);
          step_ctl.push_back({p[0], r[0], u[0], d[0], s[0]});
          step_cycles.push_back(c);
          step_period.push_back(ipod_pkg::period_t'(e));
          total_cycles += c;
        end
      end
      $fclose(fd);
      // Twice the whole run, reset included
      watchdog_ns = 2 * (total_cycles + 8 + step_ctl.size()) * 20;
      trace_loaded = 1'b1;
    end
  end

  // Flash slave, random wait states
  always @(posedge CLK_50M)
  begin
    #2;
    if (wb_ack)
    begin
      wb_ack = 1'b0;
      busy   = 1'b0;
    end
    else if (wb_cyc && wb_stb)
    begin
      if (!busy)
      begin
        busy      = 1'b1;
        ack_delay = $unsigned($random(seed)) % 4;
      end
      if (ack_delay == 0)
      begin
        wb_ack = 1'b1;
        wb_dat = mem[wb_adr];
      end
      else
        ack_delay--;
    end
  end

  // ==============================
  // Output monitor
  // ==============================
  always @(negedge CLK_50M)
  begin
    if (!reset)
    begin
      gap++;
      period_changed = (sample_period != period_prev);
      if (audio_valid)
      begin
        if (!play_prev)
        begin
          timing_errors++;
          $display("ERROR %0t: audio_valid while paused", $time);
        end
        check_audio(audio, expected_audio(exp_addr, exp_half));
        if (exp_half)
          exp_addr = (exp_addr == int'(LAST_ADDR)) ? 0 : exp_addr + 1;
        exp_half = !exp_half;
        audio_count++;
        // Steady period and play, so the gap is one period
        if (clean && !period_changed && gap != int'(sample_period))
        begin
          timing_errors++;
          $display("ERROR %0t: sample gap %0d cycles, expected %0d", $time, gap,
                   sample_period);
        end
        gap   = 0;
        clean = play && !period_changed && !restart;
      end
      else if (period_changed || !play || restart)
        clean = 1'b0;
    end
    play_prev   = play;
    period_prev = sample_period;
  end

  // ==============================
  // Step driver
  // ==============================
  initial
  begin : run_steps
    int total;
    seed          = 25507;
    busy          = 1'b0;
    ack_delay     = 0;
    exp_addr      = 0;
    exp_half      = 1'b0;
    audio_count   = 0;
    gap           = 0;
    clean         = 1'b0;
    play_prev     = 1'b0;
    period_prev   = ipod_pkg::DEFAULT_PERIOD;
    audio_errors  = 0;
    period_errors = 0;
    timing_errors = 0;
    reset         = 1'b1;
    play          = 1'b0;
    restart       = 1'b0;
    speed_up      = 1'b0;
    speed_down    = 1'b0;
    speed_reset   = 1'b0;
    wb_ack        = 1'b0;
    wb_dat        = '0;
    wait (trace_loaded);
    repeat (8) @(posedge CLK_50M);
    #2;
    reset = 1'b0;
    for (int i = 0; i < step_ctl.size(); i++)
    begin
      // Restart rising edge, playback starts over at word 0
      if (step_ctl[i][3] && !restart)
      begin
        exp_addr = 0;
        exp_half = 1'b0;
      end
      {play, restart, speed_up, speed_down, speed_reset} = step_ctl[i];
      repeat (step_cycles[i]) @(posedge CLK_50M);
      #2;
      check_period(sample_period, step_period[i]);
    end
    if (audio_count < MIN_AUDIO)
    begin
      timing_errors++;
      $display("Only %0d audio bytes were played, at least %0d expected", audio_count,
               MIN_AUDIO);
    end
    total = audio_errors + period_errors + timing_errors + i_dut.i_assert.failures;
    $display("Errors: audio %0d, period %0d, timing %0d, assertion %0d (%0d bytes)",
             audio_errors, period_errors, timing_errors, i_dut.i_assert.failures,
             audio_count);
    if (total == 0)
      $display("Simulation PASSED");
    else
      $display("Simulation FAILED");
    $finish;
  end

  // Hang guard
  initial
  begin : watchdog
    wait (trace_loaded);
    #(watchdog_ns);
    $display("Timeout after %0d ns, the steps never finished", watchdog_ns);
    $display("Simulation FAILED");
    $finish;
  end

endmodule

//--- files.f
hw/ipod_pkg.sv
hw/flash_sample_reader.sv
hw/sample_fifo.sv
hw/speed_period_ctrl.sv
hw/sample_rate_player.sv
hw/ipod_player_top.sv
sim/ipod_player_assertions.sv
sim/tb_ipod_player.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal -j 0
TOP       = tb_ipod_player
FILELIST  = files.f
BUILD_DIR = obj_dir
RUN_FLAGS = +verilator+error+limit+100
PASS_MSG  = Simulation PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	@out="$$(./$(BUILD_DIR)/V$(TOP) $(RUN_FLAGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

//--- sim/ipod_trace.txt
# M addr word    flash word address and contents in hex
# S play restart up down reset cycles period    inputs held for cycles, then expected period
M 0 9A3C1F07
M 1 2B11E480
M 2 7F0080FF
M 3 0455C3AA
M 4 66D23981
M 5 F10E5A5A
M 6 01FEB7C4
M 7 CC334870
S 0 0 0 0 0 40 1136
S 1 0 0 0 0 6000 1136
S 1 0 1 0 0 1 1036
S 1 0 0 0 0 3000 1036
S 1 0 0 1 0 1 1136
S 1 0 0 0 0 10 1136
S 1 0 1 0 0 160 736
S 1 0 0 0 0 3000 736
S 1 0 1 0 0 360 236
S 1 0 0 0 0 2000 236
S 1 0 0 0 1 1 1136
S 1 0 0 1 0 1500 4036
S 1 0 0 0 0 9000 4036
S 1 0 0 0 1 1 1136
S 0 0 0 0 0 3000 1136
S 1 0 0 0 0 3000 1136
S 0 0 0 0 0 20 1136
S 0 1 0 0 0 2 1136
S 0 0 0 0 0 40 1136
S 1 0 0 0 0 5000 1136
